/* list.f */
+incdir+tb
verilog/exec_pkg.sv
verilog/op_decode.sv
verilog/operand_bypass.sv
verilog/int_alu.sv
verilog/int_shifter.sv
verilog/agu_adder.sv
verilog/int_exec_cluster.sv
tb/tb_int_exec_cluster.sv

/* Bender.yml */
package:
  name: int_exec_cluster

sources:
  - verilog/exec_pkg.sv
  - verilog/op_decode.sv
  - verilog/operand_bypass.sv
  - verilog/int_alu.sv
  - verilog/int_shifter.sv
  - verilog/agu_adder.sv
  - verilog/int_exec_cluster.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_int_exec_cluster.sv

/* tb/exec_vectors.svh */
// ~~~~~~~~~~~~~~~~~~~~
// directed vectors for the cluster
// one add_row per issue cycle: group, lane 0, lane 1.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

task automatic fill_table();
  // alu_vec: op, wide, a, b, flags in, expected res, expected flags.
  add_row(T_ARITH, alu_vec(op_add, 1, 64'h1, 64'h2, 4'b0000, 64'h3, 4'b0000),
          alu_vec(op_add, 0, 64'hffff_ffff, 64'h1, 4'b0000, 64'h0, 4'b1010));
  add_row(T_ARITH, alu_vec(op_add, 1, 64'h7fff_ffff_ffff_ffff, 64'h1, 4'b0000,
                           64'h8000_0000_0000_0000, 4'b0101),
          alu_vec(op_add, 1, 64'hffff_ffff_ffff_ffff, 64'h1, 4'b0000, 64'h0, 4'b1010));
  add_row(T_ARITH, alu_vec(op_add, 0, 64'h7fff_ffff, 64'h1, 4'b0000, 64'h8000_0000, 4'b0101),
          alu_vec(op_adc, 1, 64'h5, 64'h6, 4'b0010, 64'hc, 4'b0000));
  add_row(T_ARITH, alu_vec(op_sub, 1, 64'h5, 64'h7, 4'b0000, 64'hffff_ffff_ffff_fffe, 4'b0110),
          alu_vec(op_sub, 0, 64'hdead_beef_8000_0000, 64'h1, 4'b0000, 64'h7fff_ffff, 4'b0001));
  add_row(T_ARITH, alu_vec(op_cmp, 1, 64'h9, 64'h9, 4'b0000, 64'h0, 4'b1000),
          alu_vec(op_cmp, 0, 64'h1, 64'h2, 4'b0000, 64'h0, 4'b0110));
  add_row(T_ARITH, alu_vec(op_and, 1, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00, 4'b0000,
                           64'hf000_f000_f000_f000, 4'b0100),
          alu_vec(op_or, 0, 64'hffff_ffff_0000_1234, 64'h8000_0000, 4'b0000,
                  64'h8000_1234, 4'b0100));
  add_row(T_ARITH, alu_vec(op_xor, 0, 64'h1234_5678_aaaa_aaaa, 64'haaaa_aaaa, 4'b0000,
                           64'h0, 4'b1000),
          alu_vec(op_xor, 1, 64'h1, 64'h3, 4'b0000, 64'h2, 4'b0000));
  add_row(T_ARITH, alu_vec(op_and, 0, '1, '1, 4'b0000, 64'hffff_ffff, 4'b0100),
          alu_vec(op_add, 0, 64'h7fff_ffff, 64'h7fff_ffff, 4'b0000, 64'hffff_fffe, 4'b0101));
  add_row(T_ARITH, alu_vec(op_adc, 0, 64'hffff_ffff, 64'h0, 4'b0010, 64'h0, 4'b1010),
          alu_vec(op_sub, 1, 64'h0, 64'h1, 4'b0000, '1, 4'b0110));
  add_row(T_ARITH, alu_vec(op_sub, 1, 64'h8000_0000_0000_0000, 64'h1, 4'b0000,
                           64'h7fff_ffff_ffff_ffff, 4'b0001),
          alu_vec(op_cmp, 1, '1, 64'h1, 4'b0000, 64'h0, 4'b0100));
  // lea_vec: wide, base, index, disp, scale, flags in, expected address.
  add_row(T_SHIFT, lea_vec(1, 64'h1000, 64'h10, 32'h20, 2'd0, 4'b0101, 64'h1030),
          alu_vec(op_shl, 1, 64'h1, 64'h0, 4'b0000, 64'h1, 4'b0000));
  add_row(T_SHIFT, lea_vec(1, 64'h1000, 64'h10, 32'h0, 2'd1, 4'b1000, 64'h1020),
          alu_vec(op_shl, 1, 64'h1, 64'd63, 4'b0000, 64'h8000_0000_0000_0000, 4'b0100));
  add_row(T_SHIFT, lea_vec(1, 64'h1000, 64'h10, 32'hffff_fff8, 2'd2, 4'b0011, 64'h1038),
          alu_vec(op_shl, 0, 64'h1, 64'd31, 4'b0000, 64'h8000_0000, 4'b0100));
  add_row(T_SHIFT, lea_vec(1, 64'h1000, 64'h10, 32'h0, 2'd3, 4'b0000, 64'h1080),
          alu_vec(op_shl, 0, 64'h1, 64'd63, 4'b0000, 64'h8000_0000, 4'b0100));
  add_row(T_SHIFT, lea_vec(0, 64'h1_ffff_fff0, 64'h20, 32'h0, 2'd0, 4'b0110, 64'h10),
          alu_vec(op_shr, 1, 64'h8000_0000_0000_0000, 64'd63, 4'b0000, 64'h1, 4'b0000));
  add_row(T_SHIFT, lea_vec(1, 64'h100, 64'h0, 32'hffff_ff00, 2'd0, 4'b1111, 64'h0),
          alu_vec(op_shr, 0, 64'hffff_ffff_8000_0000, 64'd31, 4'b0000, 64'h1, 4'b0000));
  add_row(T_SHIFT, idle_vec(),
          alu_vec(op_sar, 1, 64'h8000_0000_0000_0000, 64'd63, 4'b0000, '1, 4'b0100));
  add_row(T_SHIFT, idle_vec(),
          alu_vec(op_sar, 0, 64'h8000_0000, 64'd31, 4'b0000, 64'hffff_ffff, 4'b0100));
  add_row(T_SHIFT, idle_vec(),
          alu_vec(op_sar, 0, 64'h8000_0000, 64'd1, 4'b0000, 64'hc000_0000, 4'b0100));
  add_row(T_SHIFT, idle_vec(),
          alu_vec(op_shr, 1, 64'hff, 64'h41, 4'b0000, 64'h7f, 4'b0000));
  add_row(T_SHIFT, idle_vec(),
          alu_vec(op_shr, 0, 64'hffff_ffff_1234_5678, 64'h0, 4'b0000, 64'h1234_5678, 4'b0000));
  // fwd_vec: op, a src, b src, flags src, a, b, disp, scale.
  add_row(T_FWD, fwd_vec(op_add, src_reg, src_reg, src_reg, 64'h10, 64'h5, 32'h0, 2'd0),
          fwd_vec(op_add, src_reg, src_reg, src_reg, 64'h100, 64'h1, 32'h0, 2'd0));
  add_row(T_FWD, fwd_vec(op_add, src_l0_now, src_l1_now, src_l1_now, 0, 0, 32'h0, 2'd0),
          fwd_vec(op_sub, src_l0_now, src_reg, src_l0_now, 0, 64'h1, 32'h0, 2'd0));
  add_row(T_FWD, fwd_vec(op_adc, src_l0_prev, src_l1_prev, src_l1_now, 0, 0, 32'h0, 2'd0),
          fwd_vec(op_xor, src_l1_now, src_l0_prev, src_l0_prev, 0, 0, 32'h0, 2'd0));
  add_row(T_FWD, fwd_vec(op_sub, src_l1_now, src_l0_now, src_l1_prev, 0, 0, 32'h0, 2'd0),
          fwd_vec(op_shl, src_l0_prev, src_reg, src_l0_now, 0, 64'h4, 32'h0, 2'd0));
  add_row(T_FWD, fwd_vec(op_lea, src_l1_now, src_l1_prev, src_l1_now, 0, 0, 32'h4, 2'd1),
          fwd_vec(op_cmp, src_l0_now, src_l0_prev, src_l0_now, 0, 0, 32'h0, 2'd0));
  add_row(T_FWD, fwd_vec(op_and, src_l0_now, src_l1_prev, src_l1_prev, 0, 0, 32'h0, 2'd0),
          fwd_vec(op_or, src_l1_prev, src_l0_now, src_l0_prev, 0, 0, 32'h0, 2'd0));
endtask

`endif

/* tb/tb_int_exec_cluster.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the two-lane execution cluster
// table rows then a random run, checked two edges later.
// ~~~~~~~~~~~~~~~~~~~~
module tb_int_exec_cluster import exec_pkg::*; ();

  localparam logic [31:0] SEED = 32'h2bf83744;
  localparam int N_RAND = 48;
  localparam int T_RESET = 0, T_ARITH = 1, T_SHIFT = 2, T_FWD = 3, T_THRU = 4;

  typedef struct packed {
    logic   valid;
    op_t    op;
    logic   wide;
    word_t  a;
    word_t  b;
    src_t   a_src;
    src_t   b_src;
    flags_t flags;
    src_t   flags_src;
    disp_t  disp;
    scale_t scale;
    logic   use_model;  // expected values come from the model.
    word_t  exp_res;
    flags_t exp_flags;
  } lane_vec_t;

  logic clk, arst_n;
  logic l0_valid, l1_valid, l0_wide, l1_wide;
  op_t l0_op, l1_op;
  word_t l0_a, l0_b, l1_a, l1_b;
  src_t l0_a_src, l0_b_src, l0_flags_src, l1_a_src, l1_b_src, l1_flags_src;
  flags_t l0_flags, l1_flags;
  disp_t l0_disp;
  scale_t l0_scale;
  logic l0_res_valid, l1_res_valid;
  word_t l0_res, l1_res;
  flags_t l0_res_flags, l1_res_flags;

  lane_vec_t l0_q[$];
  lane_vec_t l1_q[$];
  int grp_q[$];
  word_t cur_res[2], prev_res[2];
  flags_t cur_flags[2], prev_flags[2];
  int n_checks, n_errors;
  int test_chk[5], test_err[5];

  int_exec_cluster u_int_exec_cluster (.*);

  function automatic lane_vec_t alu_vec(input op_t op, input logic wide, input word_t a,
      input word_t b, input flags_t f, input word_t er, input flags_t ef);
    lane_vec_t v;
    v = '0;
    v.valid = 1'b1;
    v.op = op;
    v.wide = wide;
    v.a = a;
    v.b = b;
    v.flags = f;
    v.exp_res = er;
    v.exp_flags = ef;
    return v;
  endfunction

  function automatic lane_vec_t lea_vec(input logic wide, input word_t a, input word_t b,
      input disp_t d, input scale_t s, input flags_t f, input word_t er);
    lane_vec_t v;
    v = alu_vec(op_lea, wide, a, b, f, er, f);  // flags pass through.
    v.disp = d;
    v.scale = s;
    return v;
  endfunction

  function automatic lane_vec_t fwd_vec(input op_t op, input src_t as, input src_t bs,
      input src_t fs, input word_t a, input word_t b, input disp_t d, input scale_t s);
    lane_vec_t v;
    v = lea_vec(1'b1, a, b, d, s, 4'b0000, '0);
    v.op = op;
    v.a_src = as;
    v.b_src = bs;
    v.flags_src = fs;
    v.use_model = 1'b1;
    return v;
  endfunction

  function automatic lane_vec_t idle_vec();
    return '0;
  endfunction

  function automatic lane_vec_t rand_vec(input int lane);
    lane_vec_t v;
    int r;
    v = '0;
    v.valid = 1'b1;
    v.use_model = 1'b1;
    r = $urandom_range(lane == 0 ? 7 : 9, 0);
    v.op = op_t'((lane == 1 && r > 6) ? r + 1 : r);  // lane 1 skips lea.
    v.wide = $urandom_range(1, 0);
    v.a = {$urandom, $urandom};
    v.b = {$urandom, $urandom};
    v.a_src = src_t'($urandom_range(4, 0));
    v.b_src = src_t'($urandom_range(4, 0));
    v.flags_src = src_t'($urandom_range(4, 0));
    v.flags = flags_t'($urandom_range(15, 0));
    v.disp = $urandom;
    v.scale = $urandom_range(3, 0);
    return v;
  endfunction

  task automatic add_row(input int g, input lane_vec_t v0, input lane_vec_t v1);
    l0_q.push_back(v0);
    l1_q.push_back(v1);
    grp_q.push_back(g);
  endtask

  `include "exec_vectors.svh"

  // reference behavior of one lane, written from the op rules.
  task automatic model_op(input op_t op, input logic wide, input word_t a, input word_t b,
      input flags_t fin, input disp_t disp, input scale_t scale,
      output word_t r, output flags_t f);
    word_t mask, am, bm, x, sr;
    logic [64:0] full;
    logic [5:0] amt;
    int w;
    mask = wide ? '1 : 64'hffff_ffff;
    w = wide ? 64 : 32;
    am = a & mask;
    bm = b & mask;
    amt = wide ? b[5:0] : {1'b0, b[4:0]};
    f = '0;
    case (op)
      op_add, op_adc: begin
        full = {1'b0, am} + {1'b0, bm} + ((op == op_adc && fin.carry) ? 65'd1 : 65'd0);
        x = full[63:0] & mask;
        f.carry = full[w];
        f.overflow = (am[w-1] == bm[w-1]) && (x[w-1] != am[w-1]);
      end
      op_sub, op_cmp: begin
        x = (am - bm) & mask;
        f.carry = am < bm;
        f.overflow = (am[w-1] != bm[w-1]) && (x[w-1] != am[w-1]);
      end
      op_and: x = (a & b) & mask;
      op_or:  x = (a | b) & mask;
      op_xor: x = (a ^ b) & mask;
      op_lea: x = (a + (b << scale) + {{32{disp[31]}}, disp}) & mask;
      op_shl: x = (am << amt) & mask;
      op_shr: x = am >> amt;
      default: begin
        // sar fills from the sign bit of the chosen width.
        if (wide) begin
          sr = $signed(a) >>> amt;
        end else begin
          sr = $signed({{32{a[31]}}, a[31:0]}) >>> amt;
        end
        x = sr & mask;
      end
    endcase
    f.zero = (x == '0);
    f.sign = x[w-1];
    r = (op == op_cmp) ? '0 : x;
    if (op == op_lea) f = fin;
  endtask

  function automatic word_t pick_word(input src_t s, input word_t reg_v);
    case (s)
      src_l0_now:  return cur_res[0];
      src_l1_now:  return cur_res[1];
      src_l0_prev: return prev_res[0];
      src_l1_prev: return prev_res[1];
      default:     return reg_v;
    endcase
  endfunction

  function automatic flags_t pick_flags(input src_t s, input flags_t reg_v);
    case (s)
      src_l0_now:  return cur_flags[0];
      src_l1_now:  return cur_flags[1];
      src_l0_prev: return prev_flags[0];
      src_l1_prev: return prev_flags[1];
      default:     return reg_v;
    endcase
  endfunction

  task automatic predict(inout lane_vec_t v);
    word_t r;
    flags_t f;
    model_op(v.op, v.wide, pick_word(v.a_src, v.a), pick_word(v.b_src, v.b),
             pick_flags(v.flags_src, v.flags), v.disp, v.scale, r, f);
    if (v.use_model) begin
      v.exp_res = r;
      v.exp_flags = f;
    end
  endtask

  task automatic drive_idle();
    {l0_valid, l0_op, l0_wide, l0_a, l0_b, l0_a_src, l0_b_src} = '0;
    {l0_flags, l0_flags_src, l0_disp, l0_scale} = '0;
    {l1_valid, l1_op, l1_wide, l1_a, l1_b, l1_a_src, l1_b_src, l1_flags, l1_flags_src} = '0;
  endtask

  task automatic drive_row(input int k);
    lane_vec_t v0, v1;
    v0 = l0_q[k];
    v1 = l1_q[k];
    {l0_valid, l0_op, l0_wide, l0_a, l0_b, l0_a_src, l0_b_src} =
        {v0.valid, v0.op, v0.wide, v0.a, v0.b, v0.a_src, v0.b_src};
    {l0_flags, l0_flags_src, l0_disp, l0_scale} = {v0.flags, v0.flags_src, v0.disp, v0.scale};
    {l1_valid, l1_op, l1_wide, l1_a, l1_b, l1_a_src, l1_b_src, l1_flags, l1_flags_src} =
        {v1.valid, v1.op, v1.wide, v1.a, v1.b, v1.a_src, v1.b_src, v1.flags, v1.flags_src};
    predict(v0);
    predict(v1);
    l0_q[k] = v0;
    l1_q[k] = v1;
    // forwarding state moves on every cycle; results only on valid.
    prev_res = cur_res;
    prev_flags = cur_flags;
    if (v0.valid) {cur_res[0], cur_flags[0]} = {v0.exp_res, v0.exp_flags};
    if (v1.valid) {cur_res[1], cur_flags[1]} = {v1.exp_res, v1.exp_flags};
  endtask

  task automatic check_lane(input int k, input string name, input lane_vec_t v,
      input logic vld, input word_t res, input flags_t fl);
    n_checks++;
    if (vld !== v.valid) begin
      $display("error row %0d: %s_res_valid got %h expected %h", k, name, vld, v.valid);
      n_errors++;
    end else if (v.valid && res !== v.exp_res) begin
      $display("error row %0d: %s_res got %h expected %h", k, name, res, v.exp_res);
      n_errors++;
    end else if (v.valid && fl !== v.exp_flags) begin
      $display("error row %0d: %s_res_flags got %h expected %h", k, name, fl, v.exp_flags);
      n_errors++;
    end
  endtask

  task automatic report_test(input int g);
    string names[5];
    names = '{"reset", "arith_logic", "shift_lea", "forwarding", "throughput"};
    $display("test %s: %0d checks, %0d errors", names[g], test_chk[g], test_err[g]);
  endtask

  task automatic check_row(input int k);
    int g, c, e;
    g = grp_q[k];
    c = n_checks;
    e = n_errors;
    check_lane(k, "l0", l0_q[k], l0_res_valid, l0_res, l0_res_flags);
    check_lane(k, "l1", l1_q[k], l1_res_valid, l1_res, l1_res_flags);
    test_chk[g] += n_checks - c;
    test_err[g] += n_errors - e;
    if (k == grp_q.size() - 1 || grp_q[k+1] != g) report_test(g);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    int total;
    lane_vec_t idle;
    arst_n = 1'b0;
    drive_idle();
    void'($urandom(SEED));
    fill_table();
    repeat (N_RAND) add_row(T_THRU, rand_vec(0), rand_vec(1));
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    idle = idle_vec();
    repeat (3) begin
      @(negedge clk);
      check_lane(-1, "l0", idle, l0_res_valid, l0_res, l0_res_flags);
      check_lane(-1, "l1", idle, l1_res_valid, l1_res, l1_res_flags);
    end
    test_chk[T_RESET] = n_checks;
    test_err[T_RESET] = n_errors;
    report_test(T_RESET);
    total = l0_q.size();
    for (int k = 0; k < total + 2; k++) begin
      @(negedge clk);
      if (k >= 2) check_row(k - 2);
      if (k < total) drive_row(k);
      else drive_idle();
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // four cycles per row plus reset and a margin.
  initial begin
    int limit;
    #1;
    limit = l0_q.size() * 4 + 16 + 40;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* verilog/int_exec_cluster.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// two-lane integer execution cluster
// lane 0 alu with agu, lane 1 alu with shifter,
// operands forwarded from both lanes' results.
// ~~~~~~~~~~~~~~~~~~~~
module int_exec_cluster import exec_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   l0_valid,
  input  op_t    l0_op,
  input  logic   l0_wide,
  input  word_t  l0_a,
  input  word_t  l0_b,
  input  src_t   l0_a_src,
  input  src_t   l0_b_src,
  input  flags_t l0_flags,
  input  src_t   l0_flags_src,
  input  disp_t  l0_disp,
  input  scale_t l0_scale,
  input  logic   l1_valid,
  input  op_t    l1_op,
  input  logic   l1_wide,
  input  word_t  l1_a,
  input  word_t  l1_b,
  input  src_t   l1_a_src,
  input  src_t   l1_b_src,
  input  flags_t l1_flags,
  input  src_t   l1_flags_src,
  output logic   l0_res_valid,
  output word_t  l0_res,
  output flags_t l0_res_flags,
  output logic   l1_res_valid,
  output word_t  l1_res,
  output flags_t l1_res_flags
);

  logic       l0_issue, l1_issue;
  logic       l0_add_sub, l1_add_sub;
  logic       l0_use_carry, l1_use_carry;
  logic [1:0] l0_logic_fn, l1_logic_fn;
  logic       l0_write_flags, l1_write_flags;
  side_sel_t  l0_side_sel, l1_side_sel;
  logic       l0_wide_q, l1_wide_q;
  word_t      l0_a_op, l0_b_op, l1_a_op, l1_b_op;
  flags_t     l0_flags_op, l1_flags_op;
  word_t      l0_side_res, l1_side_res;
  scale_t     l0_scale_q;
  logic       l1_shift_arith, l1_shift_left;

  // lane 0.
  op_decode #(.LANE_ID(0)) u_l0_decode (
    .clk(clk), .arst_n(arst_n), .valid(l0_valid), .op(l0_op), .wide(l0_wide),
    .scale(l0_scale), .issue(l0_issue), .add_sub(l0_add_sub), .use_carry(l0_use_carry),
    .logic_fn(l0_logic_fn), .write_flags(l0_write_flags), .side_sel(l0_side_sel),
    .shift_arith(), .shift_left(), .wide_q(l0_wide_q), .scale_q(l0_scale_q)
  );

  operand_bypass #(.payload_t(word_t)) u_l0_a_byp (
    .clk(clk), .arst_n(arst_n), .reg_val(l0_a), .src(l0_a_src),
    .l0_now(l0_res), .l1_now(l1_res), .operand(l0_a_op)
  );

  operand_bypass #(.payload_t(word_t)) u_l0_b_byp (
    .clk(clk), .arst_n(arst_n), .reg_val(l0_b), .src(l0_b_src),
    .l0_now(l0_res), .l1_now(l1_res), .operand(l0_b_op)
  );

  operand_bypass #(.payload_t(flags_t)) u_l0_flags_byp (
    .clk(clk), .arst_n(arst_n), .reg_val(l0_flags), .src(l0_flags_src),
    .l0_now(l0_res_flags), .l1_now(l1_res_flags), .operand(l0_flags_op)
  );

  agu_adder u_l0_agu (
    .clk(clk), .arst_n(arst_n), .base(l0_a_op), .index(l0_b_op), .disp(l0_disp),
    .scale(l0_scale_q), .wide(l0_wide_q), .addr(l0_side_res)
  );

  int_alu u_l0_alu (
    .clk(clk), .arst_n(arst_n), .issue(l0_issue), .a(l0_a_op), .b(l0_b_op),
    .flags(l0_flags_op), .add_sub(l0_add_sub), .use_carry(l0_use_carry),
    .logic_fn(l0_logic_fn), .write_flags(l0_write_flags), .wide_q(l0_wide_q),
    .side_sel(l0_side_sel), .side_res(l0_side_res), .res_valid(l0_res_valid),
    .res(l0_res), .res_flags(l0_res_flags)
  );

  // lane 1, no scaled index here.
  op_decode #(.LANE_ID(1)) u_l1_decode (
    .clk(clk), .arst_n(arst_n), .valid(l1_valid), .op(l1_op), .wide(l1_wide),
    .scale(2'b00), .issue(l1_issue), .add_sub(l1_add_sub), .use_carry(l1_use_carry),
    .logic_fn(l1_logic_fn), .write_flags(l1_write_flags), .side_sel(l1_side_sel),
    .shift_arith(l1_shift_arith), .shift_left(l1_shift_left), .wide_q(l1_wide_q),
    .scale_q()
  );

  operand_bypass #(.payload_t(word_t)) u_l1_a_byp (
    .clk(clk), .arst_n(arst_n), .reg_val(l1_a), .src(l1_a_src),
    .l0_now(l0_res), .l1_now(l1_res), .operand(l1_a_op)
  );

  operand_bypass #(.payload_t(word_t)) u_l1_b_byp (
    .clk(clk), .arst_n(arst_n), .reg_val(l1_b), .src(l1_b_src),
    .l0_now(l0_res), .l1_now(l1_res), .operand(l1_b_op)
  );

  operand_bypass #(.payload_t(flags_t)) u_l1_flags_byp (
    .clk(clk), .arst_n(arst_n), .reg_val(l1_flags), .src(l1_flags_src),
    .l0_now(l0_res_flags), .l1_now(l1_res_flags), .operand(l1_flags_op)
  );

  int_shifter u_l1_shifter (
    .a(l1_a_op), .b(l1_b_op), .wide(l1_wide_q), .left(l1_shift_left),
    .arith(l1_shift_arith), .res(l1_side_res)
  );

  int_alu u_l1_alu (
    .clk(clk), .arst_n(arst_n), .issue(l1_issue), .a(l1_a_op), .b(l1_b_op),
    .flags(l1_flags_op), .add_sub(l1_add_sub), .use_carry(l1_use_carry),
    .logic_fn(l1_logic_fn), .write_flags(l1_write_flags), .wide_q(l1_wide_q),
    .side_sel(l1_side_sel), .side_res(l1_side_res), .res_valid(l1_res_valid),
    .res(l1_res), .res_flags(l1_res_flags)
  );

endmodule

/* verilog/agu_adder.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// address generation
// base + (index << scale) + sign-extended displacement.
// ~~~~~~~~~~~~~~~~~~~~
module agu_adder import exec_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  word_t  base,
  input  word_t  index,
  input  disp_t  disp,
  input  scale_t scale,
  input  logic   wide,
  output word_t  addr
);

  disp_t disp_q;
  word_t sum;

  // displacement arrives with the op, one cycle ahead of the operands.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      disp_q <= '0;
    end else begin
      disp_q <= disp;
    end
  end

  always_comb begin
    sum  = base + (index << scale) + {{(DATA_W-32){disp_q[31]}}, disp_q};
    addr = wide ? sum : {32'b0, sum[31:0]};  // 32-bit mode truncates.
  end

endmodule

/* verilog/int_shifter.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// integer shifter
// left, logical right and arithmetic right at 32 or 64 bits.
// ~~~~~~~~~~~~~~~~~~~~
module int_shifter import exec_pkg::*; (
  input  word_t a,
  input  word_t b,
  input  logic  wide,
  input  logic  left,
  input  logic  arith,
  output word_t res
);

  logic [5:0] amt;
  word_t      src_v;
  word_t      shl_v;
  word_t      shr_v;
  word_t      sar_v;
  word_t      res_full;

  always_comb begin
    // upper amount bits are ignored.
    amt = wide ? b[5:0] : {1'b0, b[4:0]};

    if (wide) begin
      src_v = a;
    end else if (arith) begin
      src_v = {{32{a[31]}}, a[31:0]};  // sign-extend before a 32-bit sar.
    end else begin
      src_v = {32'b0, a[31:0]};
    end

    shl_v = src_v << amt;
    shr_v = src_v >> amt;
    sar_v = $signed(src_v) >>> amt;

    if (left) begin
      res_full = shl_v;
    end else if (arith) begin
      res_full = sar_v;
    end else begin
      res_full = shr_v;
    end

    res = wide ? res_full : {32'b0, res_full[31:0]};
  end

endmodule

/* verilog/int_alu.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// integer alu and result stage
// add, subtract, logic ops and flags at 32 or 64 bits;
// registers its own result or the lane's side unit.
// ~~~~~~~~~~~~~~~~~~~~
module int_alu import exec_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       issue,
  input  word_t      a,
  input  word_t      b,
  input  flags_t     flags,
  input  logic       add_sub,
  input  logic       use_carry,
  input  logic [1:0] logic_fn,
  input  logic       write_flags,
  input  logic       wide_q,
  input  side_sel_t  side_sel,
  input  word_t      side_res,
  output logic       res_valid,
  output word_t      res,
  output flags_t     res_flags
);

  word_t       b_x;
  logic        carry_in;
  logic [32:0] sum_lo;
  logic [32:0] sum_hi;
  word_t       arith_res;
  logic        arith_c;
  logic        arith_v;
  word_t       logic_raw;
  word_t       flag_val;
  logic        is_arith;
  word_t       res_d;
  flags_t      flags_d;

  always_comb begin
    b_x      = add_sub ? ~b : b;
    carry_in = add_sub | (use_carry & flags.carry);
    // split adder so the 32-bit carry comes out directly.
    sum_lo   = {1'b0, a[31:0]} + {1'b0, b_x[31:0]} + {32'b0, carry_in};
    sum_hi   = {1'b0, a[63:32]} + {1'b0, b_x[63:32]} + {32'b0, sum_lo[32]};
    if (wide_q) begin
      arith_res = {sum_hi[31:0], sum_lo[31:0]};
      arith_c   = sum_hi[32] ^ add_sub;
      arith_v   = (a[63] == b_x[63]) && (sum_hi[31] != a[63]);
    end else begin
      arith_res = {32'b0, sum_lo[31:0]};
      arith_c   = sum_lo[32] ^ add_sub;
      arith_v   = (a[31] == b_x[31]) && (sum_lo[31] != a[31]);
    end

    case (logic_fn)
      LF_AND:  logic_raw = a & b;
      LF_OR:   logic_raw = a | b;
      default: logic_raw = a ^ b;
    endcase

    is_arith = (side_sel == side_alu) && (logic_fn == LF_ARITH);
    if (side_sel == side_unit) begin
      flag_val = side_res;  // the unit zero-extends on its own.
    end else if (!is_arith) begin
      flag_val = wide_q ? logic_raw : {32'b0, logic_raw[31:0]};
    end else begin
      flag_val = arith_res;
    end

    res_d = (is_arith && add_sub && use_carry) ? '0 : flag_val;  // cmp keeps flags only.

    flags_d.zero     = (flag_val == '0);
    flags_d.sign     = wide_q ? flag_val[63] : flag_val[31];
    flags_d.carry    = is_arith & arith_c;
    flags_d.overflow = is_arith & arith_v;
    if (!write_flags) begin
      flags_d = flags;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
      res       <= '0;
      res_flags <= '0;
    end else begin
      res_valid <= issue;
      if (issue) begin
        res       <= res_d;
        res_flags <= flags_d;
      end
    end
  end

endmodule

/* verilog/operand_bypass.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// operand bypass mux
// picks the register value or a result still in flight
// on either lane, now or one cycle back.
// ~~~~~~~~~~~~~~~~~~~~
module operand_bypass import exec_pkg::*; #(
  parameter type payload_t = word_t
) (
  input  logic     clk,
  input  logic     arst_n,
  input  payload_t reg_val,
  input  src_t     src,
  input  payload_t l0_now,
  input  payload_t l1_now,
  output payload_t operand
);

  src_t     src_q;
  payload_t reg_q;
  payload_t l0_prev;
  payload_t l1_prev;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      src_q <= src_reg;
    end else begin
      src_q <= src;
    end
  end

  always_ff @(posedge clk) begin
    reg_q   <= reg_val;
    l0_prev <= l0_now;  // what the lane showed during the issue cycle.
    l1_prev <= l1_now;
  end

  always_comb begin
    case (src_q)
      src_l0_now:  operand = l0_now;
      src_l1_now:  operand = l1_now;
      src_l0_prev: operand = l0_prev;
      src_l1_prev: operand = l1_prev;
      default:     operand = reg_q;
    endcase
  end

  // a bad select would quietly fall back to the register value.
  assert property (@(posedge clk) disable iff (!arst_n)
    src inside {src_reg, src_l0_now, src_l1_now, src_l0_prev, src_l1_prev})
    else $error("operand_bypass: illegal source select %0d", src);

endmodule

/* verilog/op_decode.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// lane op decoder
// samples an issued op and turns it into adder, logic,
// shifter and result-select controls for the next cycle.
// ~~~~~~~~~~~~~~~~~~~~
module op_decode import exec_pkg::*; #(
  parameter int unsigned LANE_ID = 0  // lane 0 owns the agu, lane 1 the shifter.
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      valid,
  input  op_t       op,
  input  logic      wide,
  input  scale_t    scale,
  output logic      issue,
  output logic      add_sub,
  output logic      use_carry,
  output logic [1:0] logic_fn,
  output logic      write_flags,
  output side_sel_t side_sel,
  output logic      shift_arith,
  output logic      shift_left,
  output logic      wide_q,
  output scale_t    scale_q
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue       <= 1'b0;
      add_sub     <= 1'b0;
      use_carry   <= 1'b0;
      logic_fn    <= LF_ARITH;
      write_flags <= 1'b0;
      side_sel    <= side_alu;
      shift_arith <= 1'b0;
      shift_left  <= 1'b0;
      wide_q      <= 1'b0;
      scale_q     <= '0;
    end else begin
      issue       <= valid;
      add_sub     <= (op == op_sub) || (op == op_cmp);
      // with add_sub set this marks a compare, so the result is dropped.
      use_carry   <= (op == op_adc) || (op == op_cmp);
      write_flags <= (op != op_lea);
      shift_arith <= (op == op_sar);
      shift_left  <= (op == op_shl);
      wide_q      <= wide;
      scale_q     <= scale;
      case (op)
        op_and:  logic_fn <= LF_AND;
        op_or:   logic_fn <= LF_OR;
        op_xor:  logic_fn <= LF_XOR;
        default: logic_fn <= LF_ARITH;
      endcase
      if (op inside {op_lea, op_shl, op_shr, op_sar}) begin
        side_sel <= side_unit;
      end else begin
        side_sel <= side_alu;
      end
    end
  end

  // lea only reaches lane 0 and the shifts only lane 1.
  assert property (@(posedge clk) disable iff (!arst_n)
    valid |-> ((LANE_ID == 0) ? !(op inside {op_shl, op_shr, op_sar}) : (op != op_lea)))
    else $error("op_decode: op %s issued on lane %0d", op.name(), LANE_ID);

endmodule

/* verilog/exec_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// integer execution package
// widths, op codes, operand sources and the flags layout
// shared by both lanes of the cluster.
// ~~~~~~~~~~~~~~~~~~~~
package exec_pkg;

  localparam int DATA_W = 64;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [31:0]       disp_t;
  typedef logic [1:0]        scale_t;

  // msb first: zero, sign, carry, overflow.
  typedef struct packed {
    logic zero;
    logic sign;
    logic carry;    // borrow after a subtract.
    logic overflow;
  } flags_t;

  typedef enum logic [3:0] {
    op_add, op_adc, op_sub, op_cmp,
    op_and, op_or,  op_xor, op_lea,
    op_shl, op_shr, op_sar
  } op_t;

  // now is the result on a lane's outputs, prev the one a cycle older.
  typedef enum logic [2:0] {
    src_reg,
    src_l0_now,
    src_l1_now,
    src_l0_prev,
    src_l1_prev
  } src_t;

  typedef enum logic {
    side_alu,
    side_unit  // agu on lane 0, shifter on lane 1.
  } side_sel_t;

  // logic_fn codes; arith routes the adder to the result.
  localparam logic [1:0] LF_ARITH = 2'd0;
  localparam logic [1:0] LF_AND   = 2'd1;
  localparam logic [1:0] LF_OR    = 2'd2;
  localparam logic [1:0] LF_XOR   = 2'd3;

endpackage
